// File: hdl/gpio_pkg.sv
`default_nettype none

package gpio_pkg;

    // host address layout: [3:2] slave select, [1:0] register index
    localparam int ADDR_W = 4;
    localparam int SLV_W  = 2;
    localparam int IDX_W  = 2;

    // slave field values, 2 and 3 are unmapped
    localparam logic [SLV_W-1:0] SLV_BIDIR = 2'd0;
    localparam logic [SLV_W-1:0] SLV_IN    = 2'd1;

    // register index inside one slave
    typedef enum logic [IDX_W-1:0] {
        REG_DIR   = 2'd0, // direction, 1 = drive pad
        REG_WRITE = 2'd1, // output value
        REG_READ  = 2'd2, // pad / pin value
        REG_EDGE  = 2'd3  // sticky rising-edge flags, input port only
    } reg_index_e;

    // host command controller
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_BUS  = 2'd1,
        ST_RESP = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/gpio_bus_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_bus_ctrl import gpio_pkg::*; #(
    parameter int PORT_W = 8
) (
    input  wire logic              clk,
    input  wire logic              reset,
    // host command side
    input  wire logic              cmd_valid_i,
    input  wire logic              cmd_we_i,
    input  wire logic [ADDR_W-1:0] cmd_addr_i,
    input  wire logic [PORT_W-1:0] cmd_wdata_i,
    // slave returns
    input  wire logic              bidir_ack_i,
    input  wire logic [PORT_W-1:0] bidir_rdata_i,
    input  wire logic              in_ack_i,
    input  wire logic [PORT_W-1:0] in_rdata_i,
    // internal bus
    output logic                   bus_we_o,
    output reg_index_e             bus_idx_o,
    output logic      [PORT_W-1:0] bus_wdata_o,
    output logic                   bidir_stb_o,
    output logic                   in_stb_o,
    // host response side
    output logic                   rsp_valid_o,
    output logic                   rsp_err_o,
    output logic      [PORT_W-1:0] rsp_rdata_o,
    output logic                   busy_o
);

    ctrl_state_e      state_q;
    logic             rsp_valid_q;
    logic             err_q;
    logic             we_q;
    reg_index_e       idx_q;
    logic [PORT_W-1:0] wdata_q;
    logic [PORT_W-1:0] rdata_q;
    logic [SLV_W-1:0] slv_q;

    logic             cmd_accept;
    logic [SLV_W-1:0] cmd_slv;
    logic             cmd_mapped;
    logic             sel_ack;
    logic [PORT_W-1:0] sel_rdata;

    assign busy_o     = (state_q != ST_IDLE) || rsp_valid_q;
    assign cmd_accept = cmd_valid_i && !busy_o; // no back-pressure, dropped when busy
    assign cmd_slv    = cmd_addr_i[ADDR_W-1 -: SLV_W];
    assign cmd_mapped = (cmd_slv == SLV_BIDIR) || (cmd_slv == SLV_IN);

    // ack and read data of whichever slave the latched command targets
    assign sel_ack   = (slv_q == SLV_BIDIR) ? bidir_ack_i : in_ack_i;
    assign sel_rdata = (slv_q == SLV_BIDIR) ? bidir_rdata_i : in_rdata_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= ST_IDLE;
            rsp_valid_q <= 1'b0;
            err_q       <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (cmd_accept) begin
                        err_q   <= !cmd_mapped;
                        state_q <= cmd_mapped ? ST_BUS : ST_RESP; // unmapped skips the bus
                    end
                end
                ST_BUS: begin
                    if (sel_ack) state_q <= ST_RESP;
                end
                ST_RESP: begin
                    rsp_valid_q <= 1'b1;
                    state_q     <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // command fields and captured read data
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            we_q    <= cmd_we_i;
            idx_q   <= reg_index_e'(cmd_addr_i[IDX_W-1:0]);
            wdata_q <= cmd_wdata_i;
            slv_q   <= cmd_slv;
            rdata_q <= '0; // writes and errors answer zero
        end else if (state_q == ST_BUS && sel_ack && !we_q) begin
            rdata_q <= sel_rdata;
        end
    end

    assign bus_we_o    = we_q;
    assign bus_idx_o   = idx_q;
    assign bus_wdata_o = wdata_q;
    assign bidir_stb_o = (state_q == ST_BUS) && (slv_q == SLV_BIDIR);
    assign in_stb_o    = (state_q == ST_BUS) && (slv_q == SLV_IN);

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_err_o   = rsp_valid_q && err_q;
    assign rsp_rdata_o = rdata_q;

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(bidir_stb_o && in_stb_o));

    a_rsp_pulse: assert property (@(posedge clk) disable iff (reset)
        rsp_valid_o |=> !rsp_valid_o);

endmodule

`default_nettype wire

// File: hdl/gpio_bidir_port.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_bidir_port import gpio_pkg::*; #(
    parameter int PORT_W = 8
) (
    input  wire logic              clk,
    input  wire logic              reset,
    // slave bus
    input  wire logic              stb_i,
    input  wire logic              we_i,
    input  wire reg_index_e        idx_i,
    input  wire logic [PORT_W-1:0] wdata_i,
    output logic                   ack_o,
    output logic      [PORT_W-1:0] rdata_o,
    // split pad
    input  wire logic [PORT_W-1:0] pad_i,
    output logic      [PORT_W-1:0] pad_o,
    output logic      [PORT_W-1:0] pad_oe_o
);

    logic [PORT_W-1:0] dir_q;
    logic [PORT_W-1:0] write_q;
    logic [PORT_W-1:0] read_q;
    logic              ack_q;
    logic              access;

    // first strobe cycle only, second one is the ack cycle
    assign access = stb_i && !ack_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dir_q   <= '0; // all pins input
            write_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= stb_i && !ack_q;
            if (access && we_i) begin
                case (idx_i)
                    REG_DIR:   dir_q   <= wdata_i;
                    REG_WRITE: write_q <= wdata_i;
                    default: ; // read and edge are read-only here
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && !we_i) begin
            case (idx_i)
                REG_DIR:   read_q <= dir_q;
                REG_WRITE: read_q <= write_q;
                REG_READ:  read_q <= pad_i; // pad value at the strobe
                default:   read_q <= '0;
            endcase
        end
    end

    assign ack_o    = ack_q;
    assign rdata_o  = read_q;
    assign pad_o    = write_q;
    assign pad_oe_o = dir_q;

    a_ack_pulse: assert property (@(posedge clk) disable iff (reset)
        ack_o |=> !ack_o);

endmodule

`default_nettype wire

// File: hdl/gpio_in_port.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_in_port import gpio_pkg::*; #(
    parameter int PORT_W = 8
) (
    input  wire logic              clk,
    input  wire logic              reset,
    // slave bus
    input  wire logic              stb_i,
    input  wire logic              we_i,
    input  wire reg_index_e        idx_i,
    input  wire logic [PORT_W-1:0] wdata_i,
    output logic                   ack_o,
    output logic      [PORT_W-1:0] rdata_o,
    // sampling
    input  wire logic              sample_tick_i,
    input  wire logic [PORT_W-1:0] pins_i
);

    logic [PORT_W-1:0] sync1_q;
    logic [PORT_W-1:0] sync2_q;
    logic [PORT_W-1:0] sample_q;
    logic [PORT_W-1:0] edge_q;
    logic [PORT_W-1:0] read_q;
    logic              ack_q;

    logic              access;
    logic [PORT_W-1:0] edge_set;
    logic [PORT_W-1:0] edge_clr;

    assign access = stb_i && !ack_q;

    // bits that were low in the last sample and are high now
    assign edge_set = sample_tick_i ? (sync2_q & ~sample_q) : '0;
    assign edge_clr = (access && we_i && idx_i == REG_EDGE) ? wdata_i : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync1_q  <= '0;
            sync2_q  <= '0;
            sample_q <= '0;
            edge_q   <= '0;
            ack_q    <= 1'b0;
        end else begin
            sync1_q <= pins_i;
            sync2_q <= sync1_q;
            if (sample_tick_i) sample_q <= sync2_q;
            edge_q <= (edge_q & ~edge_clr) | edge_set; // set beats clear
            ack_q  <= stb_i && !ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (access && !we_i) begin
            case (idx_i)
                REG_READ: read_q <= sample_q;
                REG_EDGE: read_q <= edge_q;
                default:  read_q <= '0; // no dir or write register
            endcase
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = read_q;

endmodule

`default_nettype wire

// File: hdl/gpio_sample_timer.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_sample_timer #(
    parameter int SAMPLE_DIV = 4
) (
    input  wire logic clk,
    input  wire logic reset,
    output logic      sample_tick_o
);

    localparam int CNT_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(SAMPLE_DIV - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             wrap;

    assign wrap = (cnt_q == CNT_MAX);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt_q <= '0;
        end else if (wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign sample_tick_o = wrap; // one cycle in every SAMPLE_DIV

    generate
        if (SAMPLE_DIV > 1) begin : g_tick_check
            a_tick_pulse: assert property (@(posedge clk) disable iff (reset)
                sample_tick_o |=> !sample_tick_o);
        end
    endgenerate

endmodule

`default_nettype wire

// File: hdl/gpio_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_subsys_top import gpio_pkg::*; #(
    parameter int PORT_W     = 8,
    parameter int SAMPLE_DIV = 4
) (
    input  wire logic              clk,
    input  wire logic              reset,
    // host
    input  wire logic              cmd_valid_i,
    input  wire logic              cmd_we_i,
    input  wire logic [ADDR_W-1:0] cmd_addr_i,
    input  wire logic [PORT_W-1:0] cmd_wdata_i,
    output logic                   rsp_valid_o,
    output logic                   rsp_err_o,
    output logic      [PORT_W-1:0] rsp_rdata_o,
    output logic                   busy_o,
    // pins
    input  wire logic [PORT_W-1:0] pad_i,
    output logic      [PORT_W-1:0] pad_o,
    output logic      [PORT_W-1:0] pad_oe_o,
    input  wire logic [PORT_W-1:0] in_pins_i
);

    logic              bus_we;
    reg_index_e        bus_idx;
    logic [PORT_W-1:0] bus_wdata;
    logic              bidir_stb;
    logic              bidir_ack;
    logic [PORT_W-1:0] bidir_rdata;
    logic              in_stb;
    logic              in_ack;
    logic [PORT_W-1:0] in_rdata;
    logic              sample_tick;

    gpio_bus_ctrl #(
        .PORT_W (PORT_W)
    ) i_gpio_bus_ctrl (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_we_i      (cmd_we_i),
        .cmd_addr_i    (cmd_addr_i),
        .cmd_wdata_i   (cmd_wdata_i),
        .bidir_ack_i   (bidir_ack),
        .bidir_rdata_i (bidir_rdata),
        .in_ack_i      (in_ack),
        .in_rdata_i    (in_rdata),
        .bus_we_o      (bus_we),
        .bus_idx_o     (bus_idx),
        .bus_wdata_o   (bus_wdata),
        .bidir_stb_o   (bidir_stb),
        .in_stb_o      (in_stb),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_err_o     (rsp_err_o),
        .rsp_rdata_o   (rsp_rdata_o),
        .busy_o        (busy_o)
    );

    gpio_sample_timer #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) i_gpio_sample_timer (
        .clk           (clk),
        .reset         (reset),
        .sample_tick_o (sample_tick)
    );

    gpio_bidir_port #(
        .PORT_W (PORT_W)
    ) i_gpio_bidir_port (
        .clk      (clk),
        .reset    (reset),
        .stb_i    (bidir_stb),
        .we_i     (bus_we),
        .idx_i    (bus_idx),
        .wdata_i  (bus_wdata),
        .ack_o    (bidir_ack),
        .rdata_o  (bidir_rdata),
        .pad_i    (pad_i),
        .pad_o    (pad_o),
        .pad_oe_o (pad_oe_o)
    );

    gpio_in_port #(
        .PORT_W (PORT_W)
    ) i_gpio_in_port (
        .clk           (clk),
        .reset         (reset),
        .stb_i         (in_stb),
        .we_i          (bus_we),
        .idx_i         (bus_idx),
        .wdata_i       (bus_wdata),
        .ack_o         (in_ack),
        .rdata_o       (in_rdata),
        .sample_tick_i (sample_tick),
        .pins_i        (in_pins_i)
    );

endmodule

`default_nettype wire

// File: tb/gpio_tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    // free-running, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// File: tb/gpio_subsys_tb.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_subsys_tb
    import gpio_pkg::*;
();

    localparam int PORT_W        = 8;
    localparam int SAMPLE_DIV    = 4;
    localparam int RESET_CYC     = 10;
    localparam int SEED          = 32'h4d30;
    localparam int LAT_MAPPED    = 3; // command edge to response edge
    localparam int LAT_UNMAPPED  = 1; // no bus cycle
    localparam int SETTLE_CYC    = 2 + 2 * SAMPLE_DIV + 1;
    localparam int N_BIDIR       = 8;
    localparam int N_SAMPLE      = 6;
    localparam int N_EDGE_ROUNDS = 2;
    localparam int N_CMDS    = 2 + 5 * N_BIDIR + N_SAMPLE + 2 + 4 * N_EDGE_ROUNDS + 6 + 4;
    localparam int N_SETTLES = N_SAMPLE + 3 * N_EDGE_ROUNDS;
    localparam int WATCHDOG_CYC = RESET_CYC + 8 * N_CMDS + SETTLE_CYC * N_SETTLES + 100;

    logic              clk;
    logic              reset;
    logic              cmd_valid;
    logic              cmd_we;
    logic [ADDR_W-1:0] cmd_addr;
    logic [PORT_W-1:0] cmd_wdata;
    logic              rsp_valid;
    logic              rsp_err;
    logic [PORT_W-1:0] rsp_rdata;
    logic              busy;
    logic [PORT_W-1:0] pad_in;
    logic [PORT_W-1:0] pad_out;
    logic [PORT_W-1:0] pad_oe;
    logic [PORT_W-1:0] in_pins;
    logic [PORT_W-1:0] ext_pins; // what the outside world drives on undriven pads

    // shadow of the DUT registers
    logic [PORT_W-1:0] sh_dir;
    logic [PORT_W-1:0] sh_write;
    logic [PORT_W-1:0] sh_edge;
    logic [PORT_W-1:0] sh_pins;

    int                cycle_cnt = 0;
    string             exp_name_q[$];
    logic [PORT_W-1:0] exp_data_q[$];
    logic              exp_err_q[$];

    gpio_tb_clock #(
        .PERIOD_NS (40)
    ) i_gpio_tb_clock (
        .clk_o (clk)
    );

    gpio_subsys_top #(
        .PORT_W     (PORT_W),
        .SAMPLE_DIV (SAMPLE_DIV)
    ) i_gpio_subsys_top (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid_i (cmd_valid),
        .cmd_we_i    (cmd_we),
        .cmd_addr_i  (cmd_addr),
        .cmd_wdata_i (cmd_wdata),
        .rsp_valid_o (rsp_valid),
        .rsp_err_o   (rsp_err),
        .rsp_rdata_o (rsp_rdata),
        .busy_o      (busy),
        .pad_i       (pad_in),
        .pad_o       (pad_out),
        .pad_oe_o    (pad_oe),
        .in_pins_i   (in_pins)
    );

    // pad loop-back: driven bits read back the output value
    assign pad_in = (pad_out & pad_oe) | (ext_pins & ~pad_oe);

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [PORT_W-1:0] exp_v,
                              input logic [PORT_W-1:0] act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("error: %s expected %h actual %h", name, exp_v, act_v));
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
            fail_run($sformatf("error: %s expected %b actual %b", name, exp_v, act_v));
    endtask

    task automatic check_count(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v)
            fail_run($sformatf("error: %s expected %0d actual %0d", name, exp_v, act_v));
    endtask

    // expected read data from the shadow registers and pin values
    function automatic logic [PORT_W-1:0] ref_read(input logic [1:0] slv,
                                                  input reg_index_e idx);
        logic [PORT_W-1:0] val;
        val = '0;
        if (slv == SLV_BIDIR) begin
            case (idx)
                REG_DIR:   val = sh_dir;
                REG_WRITE: val = sh_write;
                REG_READ:  val = (sh_write & sh_dir) | (ext_pins & ~sh_dir);
                default:   val = '0;
            endcase
        end else if (slv == SLV_IN) begin
            case (idx)
                REG_READ: val = sh_pins;
                REG_EDGE: val = sh_edge;
                default:  val = '0;
            endcase
        end
        return val;
    endfunction

    function automatic void apply_write(input logic [1:0] slv, input reg_index_e idx,
                                        input logic [PORT_W-1:0] data);
        if (slv == SLV_BIDIR && idx == REG_DIR) sh_dir = data;
        if (slv == SLV_BIDIR && idx == REG_WRITE) sh_write = data;
        if (slv == SLV_IN && idx == REG_EDGE) sh_edge = sh_edge & ~data; // write 1 to clear
    endfunction

    task automatic set_ext(input logic [PORT_W-1:0] value);
        @(negedge clk);
        ext_pins = value;
    endtask

    // hold new pin levels until the sample register has seen them
    task automatic set_pins(input logic [PORT_W-1:0] value);
        @(negedge clk);
        in_pins = value;
        sh_edge = sh_edge | (value & ~sh_pins);
        sh_pins = value;
        repeat (SETTLE_CYC) @(negedge clk);
    endtask

    task automatic expect_rsp(input string name, input logic [PORT_W-1:0] data,
                              input logic err);
        exp_name_q.push_back(name);
        exp_data_q.push_back(data);
        exp_err_q.push_back(err);
    endtask

    // one-cycle strobe, returns at the falling edge after the sampling edge
    task automatic send_cmd(input logic we, input logic [1:0] slv, input reg_index_e idx,
                            input logic [PORT_W-1:0] wdata, output int issue);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_we    = we;
        cmd_addr  = {slv, idx};
        cmd_wdata = wdata;
        @(posedge clk);
        @(negedge clk);
        issue     = cycle_cnt;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_rsp(input string name, input int issue, input int exp_lat);
        while (rsp_valid !== 1'b1) @(negedge clk);
        check_count({name, " latency"}, exp_lat, cycle_cnt - issue);
    endtask

    task automatic do_cmd(input string name, input logic we, input logic [1:0] slv,
                          input reg_index_e idx, input logic [PORT_W-1:0] wdata);
        logic              mapped;
        logic [PORT_W-1:0] exp_v;
        int                issue;
        mapped = (slv == SLV_BIDIR) || (slv == SLV_IN);
        exp_v  = (we || !mapped) ? '0 : ref_read(slv, idx);
        expect_rsp(name, exp_v, !mapped);
        send_cmd(we, slv, idx, wdata, issue);
        if (we && mapped) apply_write(slv, idx, wdata);
        wait_rsp(name, issue, mapped ? LAT_MAPPED : LAT_UNMAPPED);
    endtask

    task automatic check_pads(input string name);
        check_data({name, " pad_oe"}, sh_dir, pad_oe);
        check_data({name, " pad_o"}, sh_write, pad_out);
    endtask

    // every response is matched against the oldest pending expectation
    always @(negedge clk) begin : rsp_check
        string             nm;
        logic [PORT_W-1:0] exp_v;
        logic              exp_e;
        if (!reset && rsp_valid === 1'b1) begin
            if (exp_name_q.size() == 0) begin
                fail_run($sformatf("response with data %h arrived with no command pending",
                                   rsp_rdata));
            end else begin
                nm    = exp_name_q.pop_front();
                exp_v = exp_data_q.pop_front();
                exp_e = exp_err_q.pop_front();
                check_data(nm, exp_v, rsp_rdata);
                check_flag({nm, " err"}, exp_e, rsp_err);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge clk);
        fail_run("watchdog expired, the response never came");
    end

    initial begin : stimulus
        int unsigned       seed_dummy;
        int                issue;
        int                drop_issue;
        logic [PORT_W-1:0] val;
        logic [PORT_W-1:0] mask;
        seed_dummy = $urandom(SEED);
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_we    = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        ext_pins  = '0;
        in_pins   = '0;
        sh_dir    = '0;
        sh_write  = '0;
        sh_edge   = '0;
        sh_pins   = '0;
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // after reset
        @(negedge clk);
        check_data("reset pad_oe", '0, pad_oe);
        check_flag("reset busy", 1'b0, busy);
        check_flag("reset rsp_valid", 1'b0, rsp_valid);
        do_cmd("reset dir read", 1'b0, SLV_BIDIR, REG_DIR, '0);
        do_cmd("reset write read", 1'b0, SLV_BIDIR, REG_WRITE, '0);

        // bidirectional port registers and pad loop-back
        for (int i = 0; i < N_BIDIR; i++) begin
            set_ext(PORT_W'($urandom));
            do_cmd($sformatf("bidir dir write %0d", i), 1'b1, SLV_BIDIR, REG_DIR,
                   PORT_W'($urandom));
            check_pads($sformatf("bidir dir write %0d", i));
            do_cmd($sformatf("bidir out write %0d", i), 1'b1, SLV_BIDIR, REG_WRITE,
                   PORT_W'($urandom));
            check_pads($sformatf("bidir out write %0d", i));
            do_cmd($sformatf("bidir dir read %0d", i), 1'b0, SLV_BIDIR, REG_DIR, '0);
            do_cmd($sformatf("bidir out read %0d", i), 1'b0, SLV_BIDIR, REG_WRITE, '0);
            do_cmd($sformatf("bidir pad read %0d", i), 1'b0, SLV_BIDIR, REG_READ, '0);
        end

        // input port sampling
        for (int i = 0; i < N_SAMPLE; i++) begin
            set_pins(PORT_W'($urandom));
            do_cmd($sformatf("in sample read %0d", i), 1'b0, SLV_IN, REG_READ, '0);
        end

        // sticky rising-edge flags
        do_cmd("edge clear all", 1'b1, SLV_IN, REG_EDGE, '1);
        do_cmd("edge after clear", 1'b0, SLV_IN, REG_EDGE, '0);
        for (int r = 0; r < N_EDGE_ROUNDS; r++) begin
            set_pins('0);
            val = PORT_W'($urandom) | PORT_W'(1); // at least one rising bit
            set_pins(val);
            do_cmd($sformatf("edge rise read %0d", r), 1'b0, SLV_IN, REG_EDGE, '0);
            mask = PORT_W'($urandom);
            do_cmd($sformatf("edge mask write %0d", r), 1'b1, SLV_IN, REG_EDGE, mask);
            do_cmd($sformatf("edge mask read %0d", r), 1'b0, SLV_IN, REG_EDGE, '0);
            set_pins('0); // falling only
            do_cmd($sformatf("edge fall read %0d", r), 1'b0, SLV_IN, REG_EDGE, '0);
        end

        // unmapped slave fields
        for (int s = 2; s < 4; s++) begin
            do_cmd($sformatf("unmapped write %0d", s), 1'b1, 2'(s), REG_DIR, 8'ha5);
            do_cmd($sformatf("unmapped read %0d", s), 1'b0, 2'(s), REG_READ, '0);
        end
        do_cmd("unmapped dir check", 1'b0, SLV_BIDIR, REG_DIR, '0);
        do_cmd("unmapped out check", 1'b0, SLV_BIDIR, REG_WRITE, '0);
        check_pads("unmapped");

        // second command while busy must vanish
        val = ~sh_write;
        expect_rsp("busy first write", '0, 1'b0);
        send_cmd(1'b1, SLV_BIDIR, REG_WRITE, val, issue);
        apply_write(SLV_BIDIR, REG_WRITE, val);
        check_flag("busy after command", 1'b1, busy);
        send_cmd(1'b1, SLV_BIDIR, REG_DIR, ~sh_dir, drop_issue);
        wait_rsp("busy first write", issue, LAT_MAPPED);
        do_cmd("busy dir check", 1'b0, SLV_BIDIR, REG_DIR, '0);
        do_cmd("busy out check", 1'b0, SLV_BIDIR, REG_WRITE, '0);
        check_pads("busy drop");
        repeat (10) @(negedge clk);

        if (exp_name_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            fail_run($sformatf("%0d responses never arrived", exp_name_q.size()));
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/gpio_pkg.sv
hdl/gpio_bus_ctrl.sv
hdl/gpio_bidir_port.sv
hdl/gpio_in_port.sv
hdl/gpio_sample_timer.sv
hdl/gpio_subsys_top.sv
tb/gpio_tb_clock.sv
tb/gpio_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := gpio_subsys_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
